// ==== Makefile ====
# Verilator build, run and lint for the Speck32/64 capture target

VERILATOR  ?= verilator
TOP        ?= sca_target_tb
RTL_TOP    ?= sca_target_top
FILELIST   ?= sca_target_top.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall
PASS_MSG   ?= *** PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Fails unless the pass message shows up in the output
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// ==== dv/sca_target_tb.sv ====
/*
 * Testbench for the Speck32/64 capture target
 * LCG stimulus over APB, checked against a Speck reference model
 */
`timescale 1ns/100ps
`default_nettype none

module sca_target_tb;

  import sca_target_pkg::*;

  localparam int num_tests      = 5;
  localparam int ops_per_test   = 24;  // Encrypt test is the longest
  localparam int apb_overhead   = 60;  // Register writes and status polls per op
  localparam int timeout_cycles = 2 * num_tests * ops_per_test * (num_rounds + apb_overhead);

  logic        clk_main;
  logic        arst_n;
  apb_req_t    apb_req;
  apb_rsp_t    apb_rsp;
  logic        capture_trig;

  logic [31:0] lcg_state = 32'd16;  // Seed
  int          trig_cnt  = 0;
  int          cycle_cnt = 0;
  int          test_errs = 0;
  int          n_pass    = 0;
  int          n_fail    = 0;

  sca_target_top dut0 (
    .clk_main_i     (clk_main),
    .arst_n_i       (arst_n),
    .apb_req_i      (apb_req),
    .apb_rsp_o      (apb_rsp),
    .capture_trig_o (capture_trig)
  );

  always #4 clk_main = ~clk_main;  // 8 ns period

  always @(posedge clk_main) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= timeout_cycles) begin
      $display("Run timed out after %0d cycles without finishing the tests", cycle_cnt);
      $display("*** FAILED ***");
      $finish;
    end
  end

  // Trigger monitor, sampled mid-cycle
  always @(negedge clk_main) begin
    if (arst_n && capture_trig) begin
      trig_cnt++;
      if (!dut0.busy) begin
        test_errs++;
        $display("Trigger went high at %0t while the engine was idle", $time);
      end
    end
  end

  //////////////////////////////////////////////////
  // Stimulus and reference model
  //////////////////////////////////////////////////

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [15:0] ror16(input logic [15:0] w, input int n);
    return (w >> n) | (w << (16 - n));
  endfunction

  function automatic logic [15:0] rol16(input logic [15:0] w, input int n);
    return (w << n) | (w >> (16 - n));
  endfunction

  // Textbook Speck32/64, full round key list first
  function automatic logic [31:0] speck_model(input logic [63:0] key, input logic [31:0] pt);
    logic [15:0] l [0:num_rounds+1];
    logic [15:0] k [0:num_rounds-1];
    logic [15:0] x;
    logic [15:0] y;
    k[0] = key[15:0];
    l[0] = key[31:16];
    l[1] = key[47:32];
    l[2] = key[63:48];
    for (int i = 0; i < num_rounds - 1; i++) begin
      l[i+3] = (k[i] + ror16(l[i], 7)) ^ 16'(i);
      k[i+1] = rol16(k[i], 2) ^ l[i+3];
    end
    x = pt[31:16];
    y = pt[15:0];
    for (int i = 0; i < num_rounds; i++) begin
      x = (ror16(x, 7) + y) ^ k[i];
      y = rol16(y, 2) ^ x;
    end
    return {x, y};
  endfunction

  //////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////

  task automatic compare_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      test_errs++;
      $display("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic compare_rsp(input string name, input apb_rsp_t got, input logic exp_err);
    if (got.pslverr !== exp_err) begin
      test_errs++;
      $display("FAILED at %0t: %s pslverr is %b, expected %b", $time, name, got.pslverr, exp_err);
    end
    if (got.pready !== 1'b1) begin
      test_errs++;
      $display("FAILED at %0t: %s pready is %b, expected 1", $time, name, got.pready);
    end
  endtask

  task automatic compare_count(input string name, input int got, input int exp);
    if (got != exp) begin
      test_errs++;
      $display("FAILED at %0t: %s is %0d, expected %0d", $time, name, got, exp);
    end
  endtask

  //////////////////////////////////////////////////
  // APB master and test steps
  //////////////////////////////////////////////////

  // Setup, access, then idle, response sampled mid access
  task automatic write_reg(input logic [7:0] addr, input logic [31:0] data, input logic exp_err);
    apb_req_t req;
    apb_rsp_t rsp;
    req        = '0;
    req.psel   = 1'b1;
    req.pwrite = 1'b1;
    req.paddr  = addr;
    req.pwdata = data;
    @(posedge clk_main);
    apb_req <= req;
    req.penable = 1'b1;
    @(posedge clk_main);
    apb_req <= req;
    @(negedge clk_main);
    rsp = apb_rsp;
    @(posedge clk_main);
    apb_req <= '0;
    compare_rsp($sformatf("write %h", addr), rsp, exp_err);
  endtask

  task automatic read_reg(input logic [7:0] addr, input logic exp_err, output logic [31:0] data);
    apb_req_t req;
    apb_rsp_t rsp;
    req       = '0;
    req.psel  = 1'b1;
    req.paddr = addr;
    @(posedge clk_main);
    apb_req <= req;
    req.penable = 1'b1;
    @(posedge clk_main);
    apb_req <= req;
    @(negedge clk_main);
    rsp  = apb_rsp;
    data = rsp.prdata;
    @(posedge clk_main);
    apb_req <= '0;
    compare_rsp($sformatf("read %h", addr), rsp, exp_err);
  endtask

  task automatic poll_done(output logic [31:0] status);
    status = '0;
    while (status[status_done_bit] !== 1'b1) begin
      read_reg(reg_status_addr, 1'b0, status);
    end
  endtask

  task automatic run_encrypt(input logic [63:0] key, input logic [31:0] pt, input logic en);
    logic [31:0] rd;
    trig_cnt = 0;
    write_reg(reg_key0_addr, key[31:0], 1'b0);   // {l0, k0}
    write_reg(reg_key1_addr, key[63:32], 1'b0);  // {l2, l1}
    write_reg(reg_din_addr, pt, 1'b0);
    write_reg(reg_ctrl_addr, {29'b0, 1'b0, en, 1'b1}, 1'b0);
    poll_done(rd);
    compare_word("status", rd, 32'h2);           // Done, not busy
    read_reg(reg_dout_addr, 1'b0, rd);
    compare_word("dout", rd, speck_model(key, pt));
    compare_count("capture_trig_o cycles", trig_cnt, en ? num_rounds : 0);
  endtask

  task automatic end_test(input string name);
    if (test_errs == 0) begin
      n_pass++;
    end else begin
      n_fail++;
    end
    $display("Test %s finished with %0d errors", name, test_errs);
    test_errs = 0;
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    logic [31:0] rd;
    logic [31:0] r;
    logic [63:0] key;
    logic [31:0] pt;
    logic [7:0]  addr;
    clk_main = 1'b0;
    arst_n   = 1'b0;
    apb_req  = '0;
    repeat (10) @(posedge clk_main);
    arst_n <= 1'b1;

    for (int a = 0; a <= 'h14; a += 4) begin  // Whole map reads 0
      read_reg(8'(a), 1'b0, rd);
      compare_word($sformatf("reg %h", a), rd, 32'h0);
    end
    compare_word("capture_trig_o", {31'b0, capture_trig}, 32'h0);
    end_test("reset");

    compare_word("model vector", speck_model(64'h1918111009080100, 32'h6574694c),
                 32'ha86842f2);
    run_encrypt(64'h1918111009080100, 32'h6574694c, 1'b1);
    repeat (20) begin
      key[31:0]  = lcg_next();
      key[63:32] = lcg_next();
      pt         = lcg_next();
      r          = lcg_next();
      run_encrypt(key, pt, r[16]);
    end
    end_test("encrypt");

    run_encrypt({lcg_next(), lcg_next()}, lcg_next(), 1'b1);  // Gated on
    run_encrypt({lcg_next(), lcg_next()}, lcg_next(), 1'b0);  // Gated off
    end_test("trigger");

    key[31:0]  = lcg_next();
    key[63:32] = lcg_next();
    pt         = lcg_next();
    write_reg(reg_key0_addr, key[31:0], 1'b0);
    write_reg(reg_key1_addr, key[63:32], 1'b0);
    write_reg(reg_din_addr, pt, 1'b0);
    write_reg(reg_ctrl_addr, 32'h3, 1'b0);       // Start, trigger on
    write_reg(reg_key0_addr, ~key[31:0], 1'b1);  // All refused mid run
    write_reg(reg_key1_addr, ~key[63:32], 1'b1);
    write_reg(reg_din_addr, ~pt, 1'b1);
    write_reg(reg_ctrl_addr, 32'h4, 1'b1);
    poll_done(rd);
    read_reg(reg_dout_addr, 1'b0, rd);
    compare_word("dout", rd, speck_model(key, pt));
    read_reg(reg_key0_addr, 1'b0, rd);
    compare_word("key0", rd, key[31:0]);
    read_reg(reg_key1_addr, 1'b0, rd);
    compare_word("key1", rd, key[63:32]);
    read_reg(reg_din_addr, 1'b0, rd);
    compare_word("data_in", rd, pt);
    trig_cnt = 0;
    write_reg(reg_ctrl_addr, 32'h6, 1'b0);       // Clear, trigger on
    read_reg(reg_status_addr, 1'b0, rd);
    compare_word("status", rd, 32'h0);
    read_reg(reg_dout_addr, 1'b0, rd);
    compare_word("dout", rd, 32'h0);
    read_reg(reg_key0_addr, 1'b0, rd);
    compare_word("key0", rd, 32'h0);
    read_reg(reg_key1_addr, 1'b0, rd);
    compare_word("key1", rd, 32'h0);
    read_reg(reg_din_addr, 1'b0, rd);
    compare_word("data_in", rd, 32'h0);
    compare_count("capture_trig_o cycles", trig_cnt, 1);
    end_test("busy_clear");

    repeat (16) begin
      r    = lcg_next();
      addr = r[23:16];
      if (addr <= 8'h14 && addr[1:0] == 2'b00) begin
        addr[0] = 1'b1;                          // Push off the map
      end
      write_reg(addr, r, 1'b1);
      read_reg(addr, 1'b1, rd);
    end
    write_reg(reg_status_addr, 32'h3, 1'b1);
    write_reg(reg_dout_addr, 32'hffffffff, 1'b1);
    key[31:0]  = lcg_next();
    key[63:32] = lcg_next();
    pt         = lcg_next();
    write_reg(reg_key0_addr, key[31:0], 1'b0);
    write_reg(reg_key1_addr, key[63:32], 1'b0);
    write_reg(reg_din_addr, pt, 1'b0);
    read_reg(reg_key0_addr, 1'b0, rd);
    compare_word("key0", rd, key[31:0]);
    read_reg(reg_key1_addr, 1'b0, rd);
    compare_word("key1", rd, key[63:32]);
    read_reg(reg_din_addr, 1'b0, rd);
    compare_word("data_in", rd, pt);
    read_reg(reg_status_addr, 1'b0, rd);
    compare_word("status", rd, 32'h0);           // Read-only writes ignored
    read_reg(reg_dout_addr, 1'b0, rd);
    compare_word("dout", rd, 32'h0);
    end_test("illegal");

    $display("Tests: %0d passed, %0d failed", n_pass, n_fail);
    if (n_fail == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule : sca_target_tb

`default_nettype wire

// ==== sca_target_top.f ====
src/sca_target_pkg.sv
src/sca_reg_decode.sv
src/speck_round_exec.sv
src/sca_result_trigger.sv
src/sca_target_top.sv
dv/sca_target_tb.sv

// ==== src/sca_reg_decode.sv ====
/*
 * APB register slave for the capture target
 * Stores key, input block and trigger enable, and issues engine commands
 */
`timescale 1ns/100ps
`default_nettype none

module sca_reg_decode (
  input  wire                                  clk_main_i,
  input  wire                                  arst_n_i,
  input  sca_target_pkg::apb_req_t             apb_req_i,
  output sca_target_pkg::apb_rsp_t             apb_rsp_o,
  input  wire                                  busy_i,
  input  wire                                  done_i,
  input  wire  [sca_target_pkg::block_w-1:0]   dout_i,
  input  wire                                  cleared_i,  // Engine clear finished
  output sca_target_pkg::exec_cmd_t            exec_cmd_o,
  output logic                                 trig_en_o
);

  import sca_target_pkg::*;

  logic                  acc, wr_acc;
  logic                  addr_rw, addr_ro;
  logic                  wr_ok;
  logic [key_w-1:0]      key_q;
  logic [block_w-1:0]    din_q;
  logic                  trig_en_q;
  logic [apb_data_w-1:0] ctrl_rd, status_rd;
  exec_op_e              op;

  assign acc    = apb_req_i.psel & apb_req_i.penable;  // Access phase
  assign wr_acc = acc & apb_req_i.pwrite;

  //////////////////////////////////////////////////
  // Address decode and error
  //////////////////////////////////////////////////

  always_comb begin
    addr_rw = 1'b0;
    addr_ro = 1'b0;
    case (apb_req_i.paddr)
      reg_key0_addr, reg_key1_addr,
      reg_din_addr, reg_ctrl_addr:   addr_rw = 1'b1;
      reg_status_addr, reg_dout_addr: addr_ro = 1'b1;
      default: ;                     // Off the map
    endcase
  end

  // Writable regs are locked while the engine runs
  assign wr_ok = wr_acc & addr_rw & ~busy_i;

  assign apb_rsp_o.pready  = 1'b1;  // No wait states
  assign apb_rsp_o.pslverr = acc & (~(addr_rw | addr_ro) |
                                    (apb_req_i.pwrite & (addr_ro | busy_i)));

  //////////////////////////////////////////////////
  // Stored registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk_main_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      key_q     <= '0;
      din_q     <= '0;
      trig_en_q <= 1'b0;
    end else if (cleared_i) begin
      key_q <= '0;                   // Wipe secrets with the datapath
      din_q <= '0;
    end else if (wr_ok) begin
      case (apb_req_i.paddr)
        reg_key0_addr: key_q[31:0]  <= apb_req_i.pwdata;
        reg_key1_addr: key_q[63:32] <= apb_req_i.pwdata;
        reg_din_addr:  din_q        <= apb_req_i.pwdata;
        reg_ctrl_addr: trig_en_q    <= apb_req_i.pwdata[ctrl_trig_en_bit];
        default: ;
      endcase
    end
  end

  assign trig_en_o = trig_en_q;

  // One-cycle opcode, clear beats start
  always_comb begin
    op = OP_NONE;
    if (wr_ok && apb_req_i.paddr == reg_ctrl_addr) begin
      if (apb_req_i.pwdata[ctrl_clear_bit]) op = OP_CLEAR;
      else if (apb_req_i.pwdata[ctrl_start_bit]) op = OP_ENCRYPT;
    end
  end

  assign exec_cmd_o.op    = op;
  assign exec_cmd_o.key   = key_q;
  assign exec_cmd_o.block = din_q;

  //////////////////////////////////////////////////
  // Read mux
  //////////////////////////////////////////////////

  always_comb begin
    ctrl_rd                   = '0;
    ctrl_rd[ctrl_trig_en_bit] = trig_en_q;
    status_rd                  = '0;
    status_rd[status_busy_bit] = busy_i;
    status_rd[status_done_bit] = done_i;
  end

  always_comb begin
    apb_rsp_o.prdata = '0;
    if (apb_req_i.psel && !apb_req_i.pwrite) begin
      case (apb_req_i.paddr)
        reg_key0_addr:   apb_rsp_o.prdata = key_q[31:0];
        reg_key1_addr:   apb_rsp_o.prdata = key_q[63:32];
        reg_din_addr:    apb_rsp_o.prdata = din_q;
        reg_ctrl_addr:   apb_rsp_o.prdata = ctrl_rd;
        reg_status_addr: apb_rsp_o.prdata = status_rd;
        reg_dout_addr:   apb_rsp_o.prdata = dout_i;
        default: ;
      endcase
    end
  end

  // Opcodes only come out of a ctrl write, and the engine picks them up next cycle
  a_cmd_from_write: assert property (@(posedge clk_main_i) disable iff (!arst_n_i)
    exec_cmd_o.op != OP_NONE |-> wr_acc ##1 busy_i)
    else $error("Engine opcode without an accepted ctrl write");

  a_no_wait: assert property (@(posedge clk_main_i) disable iff (!arst_n_i)
    acc |-> apb_rsp_o.pready)
    else $error("pready low in access phase");

endmodule : sca_reg_decode

`default_nettype wire

// ==== src/sca_result_trigger.sv ====
/*
 * Output block and done flag, plus the capture trigger
 * Trigger is only passed on while the engine is busy
 */
`timescale 1ns/100ps
`default_nettype none

module sca_result_trigger (
  input  wire                                 clk_main_i,
  input  wire                                 arst_n_i,
  input  sca_target_pkg::exec_res_t           exec_res_i,
  input  wire                                 busy_i,
  input  wire                                 trig_en_i,
  output logic [sca_target_pkg::block_w-1:0]  dout_o,
  output logic                                done_o,
  output logic                                capture_trig_o
);

  import sca_target_pkg::*;

  logic [block_w-1:0] dout_q;
  logic               done_q;
  logic               busy_d;   // Busy one cycle late
  logic               busy_rise;

  assign busy_rise = busy_i & ~busy_d;

  //////////////////////////////////////////////////
  // Result register
  //////////////////////////////////////////////////

  always_ff @(posedge clk_main_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      dout_q <= '0;
      done_q <= 1'b0;
      busy_d <= 1'b0;
    end else begin
      busy_d <= busy_i;
      if (exec_res_i.cleared) begin
        dout_q <= '0;
        done_q <= 1'b0;
      end else if (exec_res_i.valid) begin
        dout_q <= exec_res_i.block;
        done_q <= 1'b1;
      end else if (busy_rise) begin
        done_q <= 1'b0;              // New operation underway
      end
    end
  end

  assign dout_o = dout_q;
  assign done_o = done_q;

  //////////////////////////////////////////////////
  // Capture trigger
  //////////////////////////////////////////////////

  // Both terms are flop outputs, so the pin follows busy edge for edge
  assign capture_trig_o = trig_en_i & busy_i;

  a_res_onehot: assert property (@(posedge clk_main_i) disable iff (!arst_n_i)
    !(exec_res_i.valid && exec_res_i.cleared))
    else $error("Result valid and cleared together");

  // Engine reports completion only during its last busy cycle
  a_res_in_busy: assert property (@(posedge clk_main_i) disable iff (!arst_n_i)
    (exec_res_i.valid || exec_res_i.cleared) |-> busy_i ##1 !busy_i)
    else $error("Result pulse outside busy window");

endmodule : sca_result_trigger

`default_nettype wire

// ==== src/sca_target_pkg.sv ====
/*
 * Shared definitions for the Speck32/64 capture target
 * Register map, cipher constants, engine enums and bus structs
 */
`default_nettype none

package sca_target_pkg;

  //////////////////////////////////////////////////
  // Cipher constants
  //////////////////////////////////////////////////

  localparam int word_w     = 16;  // Speck32 word
  localparam int block_w    = 32;  // x,y
  localparam int key_w      = 64;  // l2,l1,l0,k0
  localparam int num_rounds = 22;
  localparam int rnd_cnt_w  = 5;
  localparam int rot_a      = 7;   // Right rotate of x and l
  localparam int rot_b      = 2;   // Left rotate of y and k

  //////////////////////////////////////////////////
  // APB register map
  //////////////////////////////////////////////////

  localparam int apb_addr_w = 8;
  localparam int apb_data_w = 32;

  localparam logic [apb_addr_w-1:0] reg_key0_addr   = 8'h00; // {l0, k0}
  localparam logic [apb_addr_w-1:0] reg_key1_addr   = 8'h04; // {l2, l1}
  localparam logic [apb_addr_w-1:0] reg_din_addr    = 8'h08; // {x, y}
  localparam logic [apb_addr_w-1:0] reg_ctrl_addr   = 8'h0C;
  localparam logic [apb_addr_w-1:0] reg_status_addr = 8'h10; // RO
  localparam logic [apb_addr_w-1:0] reg_dout_addr   = 8'h14; // RO

  // Ctrl and status bit positions
  localparam int ctrl_start_bit   = 0;  // W1, not stored
  localparam int ctrl_trig_en_bit = 1;
  localparam int ctrl_clear_bit   = 2;  // W1, not stored
  localparam int status_busy_bit  = 0;
  localparam int status_done_bit  = 1;

  //////////////////////////////////////////////////
  // Engine types and bus structs
  //////////////////////////////////////////////////

  typedef enum logic [1:0] {
    OP_NONE,
    OP_ENCRYPT,
    OP_CLEAR
  } exec_op_e;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_RUN,
    ST_CLEAR
  } exec_state_e;

  typedef struct packed {
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [apb_addr_w-1:0] paddr;
    logic [apb_data_w-1:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [apb_data_w-1:0] prdata;
    logic                  pready;
    logic                  pslverr;
  } apb_rsp_t;

  typedef struct packed {
    exec_op_e             op;
    logic [key_w-1:0]     key;    // {l2, l1, l0, k0}
    logic [block_w-1:0]   block;  // {x, y}
  } exec_cmd_t;

  typedef struct packed {
    logic               valid;    // Ciphertext ready
    logic               cleared;  // Clear finished
    logic [block_w-1:0] block;
  } exec_res_t;

endpackage : sca_target_pkg

`default_nettype wire

// ==== src/sca_target_top.sv ====
/*
 * Speck32/64 side-channel capture target
 * APB register slave, round engine and gated capture trigger
 */
`timescale 1ns/100ps
`default_nettype none

module sca_target_top (
  input  wire                        clk_main_i,
  input  wire                        arst_n_i,
  input  sca_target_pkg::apb_req_t   apb_req_i,
  output sca_target_pkg::apb_rsp_t   apb_rsp_o,
  output logic                       capture_trig_o
);

  import sca_target_pkg::*;

  exec_cmd_t          exec_cmd;
  exec_res_t          exec_res;
  logic               busy;
  logic               done;
  logic               trig_en;
  logic [block_w-1:0] dout;

  //////////////////////////////////////////////////
  // Register decode
  //////////////////////////////////////////////////

  sca_reg_decode reg_decode (
    .clk_main_i (clk_main_i),
    .arst_n_i   (arst_n_i),
    .apb_req_i  (apb_req_i),
    .apb_rsp_o  (apb_rsp_o),
    .busy_i     (busy),
    .done_i     (done),
    .dout_i     (dout),
    .cleared_i  (exec_res.cleared),  // Wipes key and data_in
    .exec_cmd_o (exec_cmd),
    .trig_en_o  (trig_en)
  );

  // Cipher core
  speck_round_exec round_exec (
    .clk_main_i (clk_main_i),
    .arst_n_i   (arst_n_i),
    .exec_cmd_i (exec_cmd),
    .busy_o     (busy),
    .exec_res_o (exec_res)
  );

  // Result and trigger pin
  sca_result_trigger result_trig (
    .clk_main_i     (clk_main_i),
    .arst_n_i       (arst_n_i),
    .exec_res_i     (exec_res),
    .busy_i         (busy),
    .trig_en_i      (trig_en),
    .dout_o         (dout),
    .done_o         (done),
    .capture_trig_o (capture_trig_o)
  );

endmodule : sca_target_top

`default_nettype wire

// ==== src/speck_round_exec.sv ====
/*
 * Iterative Speck32/64 engine, one round per clock
 * Key schedule runs alongside the rounds, busy FSM with clear
 */
`timescale 1ns/100ps
`default_nettype none

module speck_round_exec (
  input  wire                        clk_main_i,
  input  wire                        arst_n_i,
  input  sca_target_pkg::exec_cmd_t  exec_cmd_i,
  output logic                       busy_o,
  output sca_target_pkg::exec_res_t  exec_res_o
);

  import sca_target_pkg::*;

  exec_state_e                state_q;
  logic                       busy_q;
  logic [rnd_cnt_w-1:0]       rnd_q;
  logic                       last_rnd;
  logic [word_w-1:0]          x_q, y_q, k_q;
  logic [2:0][word_w-1:0]     l_q;      // l_q[0] oldest
  logic [word_w-1:0]          x_nxt, y_nxt, k_nxt, l_nxt;

  function automatic logic [word_w-1:0] ror_a(input logic [word_w-1:0] w);
    return {w[rot_a-1:0], w[word_w-1:rot_a]};
  endfunction

  function automatic logic [word_w-1:0] rol_b(input logic [word_w-1:0] w);
    return {w[word_w-rot_b-1:0], w[word_w-1:word_w-rot_b]};
  endfunction

  //////////////////////////////////////////////////
  // Round and key schedule
  //////////////////////////////////////////////////

  always_comb begin
    x_nxt = (ror_a(x_q) + y_q) ^ k_q;
    y_nxt = rol_b(y_q) ^ x_nxt;
    // Next round key from the oldest l word
    l_nxt = (k_q + ror_a(l_q[0])) ^ word_w'(rnd_q);
    k_nxt = rol_b(k_q) ^ l_nxt;
  end

  assign last_rnd = (rnd_q == rnd_cnt_w'(num_rounds - 1));

  //////////////////////////////////////////////////
  // Control FSM
  //////////////////////////////////////////////////

  always_ff @(posedge clk_main_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= ST_IDLE;
      busy_q  <= 1'b0;
      rnd_q   <= '0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          rnd_q <= '0;
          case (exec_cmd_i.op)
            OP_ENCRYPT: begin
              state_q <= ST_RUN;
              busy_q  <= 1'b1;
            end
            OP_CLEAR: begin
              state_q <= ST_CLEAR;
              busy_q  <= 1'b1;
            end
            default: ;
          endcase
        end
        ST_RUN: begin
          if (last_rnd) begin
            state_q <= ST_IDLE;
            busy_q  <= 1'b0;
            rnd_q   <= '0;
          end else begin
            rnd_q <= rnd_q + 1'b1;
          end
        end
        default: begin                // ST_CLEAR, single cycle
          state_q <= ST_IDLE;
          busy_q  <= 1'b0;
        end
      endcase
    end
  end

  // Datapath, loaded on start and wiped on clear
  always_ff @(posedge clk_main_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      x_q <= '0;
      y_q <= '0;
      k_q <= '0;
      l_q <= '0;
    end else if (state_q == ST_IDLE && exec_cmd_i.op == OP_ENCRYPT) begin
      {x_q, y_q} <= exec_cmd_i.block;
      {l_q, k_q} <= exec_cmd_i.key;   // l2,l1,l0 then k0
    end else if (state_q == ST_RUN) begin
      x_q <= x_nxt;
      y_q <= y_nxt;
      k_q <= k_nxt;
      l_q <= {l_nxt, l_q[2:1]};       // Shift towards l_q[0]
    end else if (state_q == ST_CLEAR) begin
      x_q <= '0;
      y_q <= '0;
      k_q <= '0;
      l_q <= '0;
    end
  end

  assign busy_o = busy_q;

  // Result is the output of the final round, seen on the edge busy drops
  assign exec_res_o.valid   = (state_q == ST_RUN) & last_rnd;
  assign exec_res_o.cleared = (state_q == ST_CLEAR);
  assign exec_res_o.block   = {x_nxt, y_nxt};

  a_no_cmd_busy: assert property (@(posedge clk_main_i) disable iff (!arst_n_i)
    exec_cmd_i.op != OP_NONE |-> !busy_o)
    else $error("Command arrived while engine busy");

  a_rnd_range: assert property (@(posedge clk_main_i) disable iff (!arst_n_i)
    rnd_q < num_rounds)
    else $error("Round counter out of range");

endmodule : speck_round_exec

`default_nettype wire
